// File: design/rvCorePkg.sv
package rvCorePkg;

   // Data, address and instruction words
   typedef logic [31:0] wordT;

   // Architectural register index
   typedef logic [4:0] regIdT;

   // One enable per byte lane of a memory word
   typedef logic [3:0] byteMaskT;

   // Instruction function field
   typedef logic [2:0] funct3T;

   // Number of architectural registers
   localparam int regCount = 32;

   // Major opcodes, instruction bits 6 to 2
   localparam logic [4:0] opLoad   = 5'b00000;
   localparam logic [4:0] opAluImm = 5'b00100;
   localparam logic [4:0] opAuipc  = 5'b00101;
   localparam logic [4:0] opStore  = 5'b01000;
   localparam logic [4:0] opAluReg = 5'b01100;
   localparam logic [4:0] opLui    = 5'b01101;
   localparam logic [4:0] opBranch = 5'b11000;
   localparam logic [4:0] opJalr   = 5'b11001;
   localparam logic [4:0] opJal    = 5'b11011;
   localparam logic [4:0] opSystem = 5'b11100;

   // Base instruction classes
   // Invalid covers reset and unknown opcodes and never writes back
   typedef enum logic [3:0] {
      clsInvalid,
      clsLoad,
      clsAluImm,
      clsAuipc,
      clsStore,
      clsAluReg,
      clsLui,
      clsBranch,
      clsJalr,
      clsJal,
      clsSystem
   } instrClassT;

endpackage

// File: design/instrDecoder.sv
`timescale 1ns/10ps

module instrDecoder import rvCorePkg::*; (
   input  wordT       instrWord,
   output instrClassT instrClass,
   output regIdT      rdId,
   output funct3T     funct3,
   output logic       altFunct,
   output wordT       iImm,
   output wordT       addImm
);

   // Remaining immediate formats
   wordT uImm;
   wordT sImm;
   wordT bImm;
   wordT jImm;

   // Fixed instruction fields
   assign rdId     = instrWord[11:7];
   assign funct3   = instrWord[14:12];
   // Selects SUB and SRA
   assign altFunct = instrWord[30];

   // Sign bit always sits in instruction bit 31
   assign iImm = {{21{instrWord[31]}}, instrWord[30:20]};
   assign sImm = {{21{instrWord[31]}}, instrWord[30:25], instrWord[11:7]};
   assign bImm = {{20{instrWord[31]}}, instrWord[7], instrWord[30:25],
                  instrWord[11:8], 1'b0};
   assign jImm = {{12{instrWord[31]}}, instrWord[19:12], instrWord[20],
                  instrWord[30:21], 1'b0};
   assign uImm = {instrWord[31:12], 12'b0};

   // Opcode to class
   always_comb begin
      case (instrWord[6:2])
         opLoad:   instrClass = clsLoad;
         opAluImm: instrClass = clsAluImm;
         opAuipc:  instrClass = clsAuipc;
         opStore:  instrClass = clsStore;
         opAluReg: instrClass = clsAluReg;
         opLui:    instrClass = clsLui;
         opBranch: instrClass = clsBranch;
         opJalr:   instrClass = clsJalr;
         opJal:    instrClass = clsJal;
         opSystem: instrClass = clsSystem;
         // Anything else is treated as a no-op
         default:  instrClass = clsInvalid;
      endcase
   end

   // Immediate fed to the shared adder
   // LUI also takes its write-back value from here
   always_comb begin
      case (instrClass)
         clsStore:         addImm = sImm;
         clsJal:           addImm = jImm;
         clsAuipc, clsLui: addImm = uImm;
         clsBranch:        addImm = bImm;
         // Loads, ALU-immediate and JALR
         default:          addImm = iImm;
      endcase
   end

endmodule

// File: design/regFile.sv
`timescale 1ns/10ps

module regFile import rvCorePkg::*; (
   input  logic  clk,
   input  logic  fetchCapture,
   input  wordT  fetchWord,
   input  logic  writeEn,
   input  regIdT rdId,
   input  wordT  rdData,
   output wordT  rs1Val,
   output wordT  rs2Val
);

   // Register storage
   wordT regs [regCount];

   // All registers come up as zero, x0 stays there
   initial begin
      for (int i = 0; i < regCount; i++) begin
         regs[i] = '0;
      end
   end

   // Write port, x0 writes dropped
   always @(posedge clk) begin
      if (writeEn && (rdId != '0)) begin
         regs[rdId] <= rdData;
      end
   end

   // Operands read while the instruction word arrives
   // Source fields come straight from the memory word
   always_ff @(posedge clk) begin
      if (fetchCapture) begin
         rs1Val <= regs[fetchWord[19:15]];
         rs2Val <= regs[fetchWord[24:20]];
      end
   end

endmodule

// File: design/aluUnit.sv
`timescale 1ns/10ps

module aluUnit import rvCorePkg::*; (
   input  instrClassT instrClass,
   input  funct3T     funct3,
   input  logic       altFunct,
   input  wordT       rs1Val,
   input  wordT       rs2Val,
   input  wordT       pc,
   input  wordT       iImm,
   input  wordT       addImm,
   output wordT       aluResult,
   output wordT       addSum,
   output logic       branchTaken
);

   // Mirror a word so left shifts can use the right shifter
   function automatic wordT bitReverse(input wordT value);
      wordT result;
      for (int i = 0; i < 32; i++) begin
         result[i] = value[31 - i];
      end
      return result;
   endfunction

   wordT              aluIn2;
   wordT              addIn1;
   wordT              addIn2;
   logic [32:0]       diff;
   logic              lt;
   logic              ltu;
   logic              eq;
   wordT              shiftIn;
   logic signed [32:0] shiftExt;
   logic signed [32:0] shiftRes;
   wordT              shifter;
   logic              predicate;

   // Second operand, rs2 for register forms and compares
   assign aluIn2 = ((instrClass == clsAluReg) || (instrClass == clsBranch)) ? rs2Val : iImm;

   // Shared adder
   // rs1 based for ALU, memory and JALR, PC based for the rest
   assign addIn1 = ((instrClass == clsAluImm) || (instrClass == clsAluReg) ||
                    (instrClass == clsLoad) || (instrClass == clsStore) ||
                    (instrClass == clsJalr)) ? rs1Val : pc;
   assign addIn2 = (instrClass == clsAluReg) ? rs2Val : addImm;
   assign addSum = addIn1 + addIn2;

   // One 33-bit subtract gives SUB and all compares
   assign diff = {1'b0, rs1Val} - {1'b0, aluIn2};
   // Signs differ, so rs1 is less exactly when it is negative
   assign lt   = (rs1Val[31] ^ aluIn2[31]) ? rs1Val[31] : diff[32];
   assign ltu  = diff[32];
   assign eq   = (diff[31:0] == '0);

   // Single arithmetic right shifter
   // Left shift reverses the input and the output
   assign shiftIn  = (funct3 == 3'b001) ? bitReverse(rs1Val) : rs1Val;
   // Extra top bit carries the sign only for SRA
   assign shiftExt = {altFunct & rs1Val[31], shiftIn};
   assign shiftRes = shiftExt >>> aluIn2[4:0];
   assign shifter  = shiftRes[31:0];

   // Result select on funct3
   always_comb begin
      case (funct3)
         // SUB only for the register form, ADDI has an immediate in bit 30
         3'b000:  aluResult = ((instrClass == clsAluReg) && altFunct) ? diff[31:0] : addSum;
         3'b001:  aluResult = bitReverse(shifter);
         3'b010:  aluResult = {31'b0, lt};
         3'b011:  aluResult = {31'b0, ltu};
         3'b100:  aluResult = rs1Val ^ aluIn2;
         3'b101:  aluResult = shifter;
         3'b110:  aluResult = rs1Val | aluIn2;
         default: aluResult = rs1Val & aluIn2;
      endcase
   end

   // Branch conditions
   always_comb begin
      case (funct3)
         3'b000:  predicate = eq;
         3'b001:  predicate = !eq;
         3'b100:  predicate = lt;
         3'b101:  predicate = !lt;
         3'b110:  predicate = ltu;
         3'b111:  predicate = !ltu;
         // Reserved encodings never branch
         default: predicate = 1'b0;
      endcase
   end

   // Jumps always leave the sequential path
   assign branchTaken = ((instrClass == clsBranch) && predicate) ||
                        (instrClass == clsJal) || (instrClass == clsJalr);

endmodule

// File: design/loadStoreUnit.sv
`timescale 1ns/10ps

module loadStoreUnit import rvCorePkg::*; (
   input  funct3T     funct3,
   input  logic [1:0] byteOffset,
   input  wordT       rs2Val,
   input  wordT       memRdata,
   output wordT       memWdata,
   output byteMaskT   accessMask,
   output wordT       loadData
);

   logic        byteAccess;
   logic        halfAccess;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic        loadSign;

   // Access size from funct3 low bits
   // 00 byte, 01 halfword, 10 word
   assign byteAccess = (funct3[1:0] == 2'b00);
   assign halfAccess = (funct3[1:0] == 2'b01);

   // Store data replicated so every lane sees the right byte
   // Lane 0 always holds the low byte
   assign memWdata[7:0]   = rs2Val[7:0];
   assign memWdata[15:8]  = byteOffset[0] ? rs2Val[7:0] : rs2Val[15:8];
   assign memWdata[23:16] = byteOffset[1] ? rs2Val[7:0] : rs2Val[23:16];
   // Top lane gets a byte or the upper half of a halfword
   assign memWdata[31:24] = byteOffset[0] ? rs2Val[7:0] :
                            byteOffset[1] ? rs2Val[15:8] : rs2Val[31:24];

   // Byte lanes touched by the access
   always_comb begin
      if (byteAccess) begin
         accessMask = byteMaskT'(4'b0001 << byteOffset);
      end else if (halfAccess) begin
         accessMask = byteOffset[1] ? 4'b1100 : 4'b0011;
      end else begin
         accessMask = 4'b1111;
      end
   end

   // Pick the addressed halfword, then the byte within it
   assign loadHalf = byteOffset[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = byteOffset[0] ? loadHalf[15:8] : loadHalf[7:0];

   // funct3 bit 2 set means zero extension
   assign loadSign = !funct3[2] & (byteAccess ? loadByte[7] : loadHalf[15]);

   // Extended load value
   always_comb begin
      if (byteAccess) begin
         loadData = {{24{loadSign}}, loadByte};
      end else if (halfAccess) begin
         loadData = {{16{loadSign}}, loadHalf};
      end else begin
         loadData = memRdata;
      end
   end

endmodule

// File: design/coreSequencer.sv
`timescale 1ns/10ps

module coreSequencer import rvCorePkg::*; #(
   parameter wordT resetAddr = 32'h0100_0000
) (
   input  logic       clk,
   input  logic       resetn,
   input  wordT       memRdata,
   input  logic       memRbusy,
   input  logic       memWbusy,
   input  instrClassT instrClass,
   input  wordT       addSum,
   input  wordT       aluResult,
   input  wordT       loadData,
   input  wordT       addImm,
   input  logic       branchTaken,
   input  byteMaskT   accessMask,
   output wordT       instrWord,
   output wordT       pc,
   output wordT       rdData,
   output wordT       memAddr,
   output byteMaskT   memMask,
   output logic       fetchCapture,
   output logic       writeEn,
   output logic       memRstrb,
   output logic       memWstrb
);

   // Control states, one instruction at a time
   typedef enum logic [1:0] {
      waitMem,
      fetchInstr,
      waitInstr,
      execute
   } seqStateT;

   seqStateT state;
   wordT     pcPlus4;
   wordT     pcNext;
   logic     isLoad;
   logic     isStore;
   logic     inExec;
   logic     inWaitMem;

   assign isLoad    = (instrClass == clsLoad);
   assign isStore   = (instrClass == clsStore);
   assign inExec    = (state == execute);
   assign inWaitMem = (state == waitMem);

   // Next PC, jump targets come from the adder with bit 0 cleared
   assign pcPlus4 = pc + 32'd4;
   assign pcNext  = branchTaken ? {addSum[31:1], 1'b0} : pcPlus4;

   // Address mux
   // Non-memory execute already fetches from the new PC
   always_comb begin
      if ((state == fetchInstr) || (state == waitInstr)) begin
         memAddr = pc;
      end else if (inExec && !isLoad && !isStore) begin
         memAddr = pcNext;
      end else begin
         memAddr = addSum;
      end
   end

   // Strobes
   assign memRstrb = (state == fetchInstr) || (inExec && !isStore);
   assign memWstrb = inExec && isStore;

   // Lane mask only while a data access is live
   assign memMask = ((inExec || inWaitMem) && (isLoad || isStore)) ? accessMask : 4'b1111;

   // Instruction arrives
   assign fetchCapture = (state == waitInstr) && !memRbusy;

   // Write-back, repeated in waitMem until the load data settles
   assign writeEn = (inExec || inWaitMem) &&
                    !((instrClass == clsBranch) || isStore || (instrClass == clsInvalid));

   // Write-back data
   always_comb begin
      case (instrClass)
         clsLui:              rdData = addImm;
         clsAluImm, clsAluReg: rdData = aluResult;
         clsAuipc:            rdData = addSum;
         clsJal, clsJalr:     rdData = pcPlus4;
         clsLoad:             rdData = loadData;
         // SYSTEM reads as zero, others never write
         default:             rdData = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         // Start by draining any pending access
         state     <= waitMem;
         pc        <= resetAddr;
         // Opcode 00001 decodes as invalid
         instrWord <= 32'h0000_0004;
      end else begin
         case (state)
            fetchInstr: state <= waitInstr;
            waitInstr: begin
               if (fetchCapture) begin
                  instrWord <= memRdata;
                  state     <= execute;
               end
            end
            execute: begin
               pc    <= pcNext;
               state <= (isLoad || isStore) ? waitMem : waitInstr;
            end
            default: begin
               if (!memRbusy && !memWbusy) begin
                  state <= fetchInstr;
               end
            end
         endcase
      end
   end

endmodule

// File: design/quarkCore.sv
`timescale 1ns/10ps

module quarkCore import rvCorePkg::*; #(
   parameter wordT resetAddr = 32'h0100_0000
) (
   input  logic     clk,
   input  logic     resetn,
   output wordT     memAddr,
   output wordT     memWdata,
   output byteMaskT memMask,
   output logic     memRstrb,
   output logic     memWstrb,
   input  wordT     memRdata,
   input  logic     memRbusy,
   input  logic     memWbusy
);

   // Sequencer outputs
   wordT       instrWord;
   wordT       pc;
   wordT       rdData;
   logic       fetchCapture;
   logic       writeEn;

   // Decoded fields
   instrClassT instrClass;
   regIdT      rdId;
   funct3T     funct3;
   logic       altFunct;
   wordT       iImm;
   wordT       addImm;

   // Operands and results
   wordT       rs1Val;
   wordT       rs2Val;
   wordT       aluResult;
   wordT       addSum;
   logic       branchTaken;
   byteMaskT   accessMask;
   wordT       loadData;

   // Control, PC and instruction latch
   coreSequencer #(
      .resetAddr(resetAddr)
   ) sequencerInst (
      .clk(clk), .resetn(resetn),
      .memRdata(memRdata), .memRbusy(memRbusy), .memWbusy(memWbusy),
      .instrClass(instrClass), .addSum(addSum), .aluResult(aluResult),
      .loadData(loadData), .addImm(addImm), .branchTaken(branchTaken),
      .accessMask(accessMask), .instrWord(instrWord), .pc(pc), .rdData(rdData),
      .memAddr(memAddr), .memMask(memMask), .fetchCapture(fetchCapture),
      .writeEn(writeEn), .memRstrb(memRstrb), .memWstrb(memWstrb)
   );

   instrDecoder decoderInst (
      .instrWord(instrWord), .instrClass(instrClass), .rdId(rdId),
      .funct3(funct3), .altFunct(altFunct), .iImm(iImm), .addImm(addImm)
   );

   // Operands captured from the raw fetched word
   regFile regFileInst (
      .clk(clk), .fetchCapture(fetchCapture), .fetchWord(memRdata),
      .writeEn(writeEn), .rdId(rdId), .rdData(rdData),
      .rs1Val(rs1Val), .rs2Val(rs2Val)
   );

   aluUnit aluInst (
      .instrClass(instrClass), .funct3(funct3), .altFunct(altFunct),
      .rs1Val(rs1Val), .rs2Val(rs2Val), .pc(pc), .iImm(iImm), .addImm(addImm),
      .aluResult(aluResult), .addSum(addSum), .branchTaken(branchTaken)
   );

   // Byte offset is the low part of the adder address
   loadStoreUnit lsuInst (
      .funct3(funct3), .byteOffset(addSum[1:0]), .rs2Val(rs2Val),
      .memRdata(memRdata), .memWdata(memWdata), .accessMask(accessMask),
      .loadData(loadData)
   );

endmodule

// File: dv/tbProgram.svh
localparam logic [31:0] baseAddr   = 32'h0100_0000;
// Load pattern, bytes 15 c3 7f 8a from lane 0 up
localparam logic [31:0] dataWord   = 32'h8a7f_c315;
localparam logic [31:0] markerWord = 32'h0000_05a5;
localparam logic [31:0] doneWord   = 32'h0000_06d1;
localparam int          doneSlot   = 31;
localparam logic [6:0]  immOp      = 7'b0010011;
localparam logic [6:0]  loadOp     = 7'b0000011;

logic [31:0] progImage[$];
int          expSlot[$];
logic [31:0] expValue[$];
// Slots behind a taken branch
int          skipSlot[$];
// Register value each store instruction writes, by program word
logic [31:0] storeData [256];

// RV32I instruction formats
function automatic logic [31:0] encR(logic [2:0] f3, logic [6:0] f7,
                                     logic [4:0] rd, rs1, rs2);
   return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] encI(logic [6:0] op, logic [2:0] f3,
                                     logic [4:0] rd, rs1, logic [11:0] imm);
   return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] encS(logic [2:0] f3, logic [4:0] rs2, rs1, logic [11:0] imm);
   return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] encB(logic [2:0] f3, logic [4:0] rs1, rs2, logic [12:0] imm);
   return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] encU(logic [6:0] op, logic [4:0] rd, logic [19:0] imm);
   return {imm, rd, op};
endfunction

function automatic logic [31:0] encJ(logic [4:0] rd, logic [20:0] imm);
   return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

// Result slot k sits at 0x300 + 4k above the base
function automatic logic [11:0] slotOff(int k);
   return 12'(12'h300 + 4 * k);
endfunction

function automatic logic [31:0] slotAddr(int k);
   return baseAddr + 32'(slotOff(k));
endfunction

// Address of the next instruction to be placed
function automatic logic [31:0] nextAddr();
   return baseAddr + 32'(4 * progImage.size());
endfunction

task automatic emit(logic [31:0] word);
   progImage.push_back(word);
endtask

// Store instruction together with the register value it writes
task automatic emitStore(logic [31:0] instr, logic [31:0] value);
   storeData[progImage.size()] = value;
   emit(instr);
endtask

// Word store relative to x1
task automatic storeReg(logic [4:0] rs, int slot, logic [31:0] value);
   emitStore(encS(3'b010, rs, 5'd1, slotOff(slot)), value);
endtask

task automatic expectWord(int slot, logic [31:0] value);
   expSlot.push_back(slot);
   expValue.push_back(value);
endtask

// Instruction writing x4, then x4 stored to its slot
task automatic emitChecked(logic [31:0] instr, int slot, logic [31:0] value);
   emit(instr);
   storeReg(5'd4, slot, value);
   expectWord(slot, value);
endtask

// Branch over one marker store
task automatic emitBranch(logic [2:0] f3, logic [4:0] rs1, rs2, bit taken, int slot);
   emit(encB(f3, rs1, rs2, 13'd8));
   storeReg(5'd7, slot, markerWord);
   if (taken) begin
      skipSlot.push_back(slot);
   end else begin
      expectWord(slot, markerWord);
   end
endtask

task automatic buildProgram();
   logic [31:0] here;
   // x1 base, x2 = 0x123, x3 = -5, x5 = 4, x7 marker
   emit(encU(7'b0110111, 5'd1, 20'h01000));
   emit(encI(immOp, 3'b000, 5'd2, 5'd0, 12'h123));
   emit(encI(immOp, 3'b000, 5'd3, 5'd0, 12'hffb));
   emit(encI(immOp, 3'b000, 5'd5, 5'd0, 12'h004));
   emit(encI(immOp, 3'b000, 5'd7, 5'd0, 12'h5a5));
   // ALU operations
   emitChecked(encR(3'b000, 7'h00, 5'd4, 5'd2, 5'd3), 0, 32'h0000_011e);
   emitChecked(encR(3'b000, 7'h20, 5'd4, 5'd2, 5'd3), 1, 32'h0000_0128);
   emitChecked(encR(3'b001, 7'h00, 5'd4, 5'd3, 5'd5), 2, 32'hffff_ffb0);
   emitChecked(encR(3'b101, 7'h00, 5'd4, 5'd3, 5'd5), 3, 32'h0fff_ffff);
   emitChecked(encR(3'b101, 7'h20, 5'd4, 5'd3, 5'd5), 4, 32'hffff_ffff);
   emitChecked(encR(3'b010, 7'h00, 5'd4, 5'd3, 5'd2), 5, 32'h0000_0001);
   emitChecked(encR(3'b011, 7'h00, 5'd4, 5'd3, 5'd2), 6, 32'h0000_0000);
   emitChecked(encR(3'b100, 7'h00, 5'd4, 5'd2, 5'd3), 7, 32'hffff_fed8);
   emitChecked(encR(3'b110, 7'h00, 5'd4, 5'd2, 5'd3), 8, 32'hffff_fffb);
   emitChecked(encR(3'b111, 7'h00, 5'd4, 5'd2, 5'd3), 9, 32'h0000_0123);
   // srai by 1
   emitChecked(encI(immOp, 3'b101, 5'd4, 5'd3, 12'h401), 10, 32'hffff_fffd);
   emitChecked(encU(7'b0110111, 5'd4, 20'habcde), 11, 32'habcd_e000);
   here = nextAddr();
   emitChecked(encU(7'b0010111, 5'd4, 20'h00001), 12, here + 32'h0000_1000);
   // Loads from the pattern word at 0x200
   emitChecked(encI(loadOp, 3'b000, 5'd4, 5'd1, 12'h201), 13, 32'hffff_ffc3);
   emitChecked(encI(loadOp, 3'b100, 5'd4, 5'd1, 12'h201), 14, 32'h0000_00c3);
   emitChecked(encI(loadOp, 3'b001, 5'd4, 5'd1, 12'h202), 15, 32'hffff_8a7f);
   emitChecked(encI(loadOp, 3'b101, 5'd4, 5'd1, 12'h202), 16, 32'h0000_8a7f);
   emitChecked(encI(loadOp, 3'b000, 5'd4, 5'd1, 12'h202), 17, 32'h0000_007f);
   emitChecked(encI(loadOp, 3'b010, 5'd4, 5'd1, 12'h200), 18, 32'h8a7f_c315);
   // Sub-word stores into one cleared slot
   storeReg(5'd0, 19, 32'h0000_0000);
   emitStore(encS(3'b000, 5'd2, 5'd1, slotOff(19)), 32'h0000_0123);
   emitStore(encS(3'b000, 5'd3, 5'd1, slotOff(19) + 12'd1), 32'hffff_fffb);
   emitStore(encS(3'b001, 5'd2, 5'd1, slotOff(19) + 12'd2), 32'h0000_0123);
   expectWord(19, 32'h0123_fb23);
   // beq, bne, blt, bge, bltu, bgeu
   emitBranch(3'b000, 5'd2, 5'd2, 1'b1, 20);
   emitBranch(3'b001, 5'd2, 5'd2, 1'b0, 21);
   emitBranch(3'b100, 5'd3, 5'd2, 1'b1, 22);
   emitBranch(3'b101, 5'd3, 5'd2, 1'b0, 23);
   emitBranch(3'b110, 5'd2, 5'd3, 1'b1, 24);
   emitBranch(3'b111, 5'd2, 5'd3, 1'b0, 25);
   // JAL over a marker store, link in x8
   here = nextAddr();
   emit(encJ(5'd8, 21'd8));
   storeReg(5'd7, 26, markerWord);
   skipSlot.push_back(26);
   storeReg(5'd8, 27, here + 32'd4);
   expectWord(27, here + 32'd4);
   // JALR to auipc base plus 12, link in x10
   here = nextAddr();
   emit(encU(7'b0010111, 5'd9, 20'h00000));
   emit(encI(7'b1100111, 3'b000, 5'd10, 5'd9, 12'd12));
   storeReg(5'd7, 28, markerWord);
   skipSlot.push_back(28);
   storeReg(5'd10, 29, here + 32'd8);
   expectWord(29, here + 32'd8);
   // SYSTEM overwrites a nonzero x11 with zero
   emit(encI(immOp, 3'b000, 5'd11, 5'd0, 12'd7));
   emit(encI(7'b1110011, 3'b010, 5'd11, 5'd0, 12'hc00));
   storeReg(5'd11, 30, 32'h0000_0000);
   expectWord(30, 32'h0000_0000);
   // Completion store, then spin
   emit(encI(immOp, 3'b000, 5'd12, 5'd0, 12'h6d1));
   storeReg(5'd12, doneSlot, doneWord);
   expectWord(doneSlot, doneWord);
   emit(encJ(5'd0, 21'd0));
endtask

// File: dv/quarkCoreTb.sv
`timescale 1ns/10ps

module quarkCoreTb;

   logic        clk;
   logic        resetn;
   logic [31:0] memAddr;
   logic [31:0] memWdata;
   logic [3:0]  memMask;
   logic        memRstrb;
   logic        memWstrb;
   logic [31:0] memRdata;
   logic        memRbusy;
   logic        memWbusy;

   // 4 KiB window repeated over the whole address space
   logic [31:0] mem [1024];
   logic [31:0] lcgState;
   int          stretch;
   int          busyLeft;

   int          mismatchCount;
   int          failureCount;
   int          resetEdges;
   int          cyclesOut;
   bit          fetchSeen;
   bit          doneSeen;
   logic [31:0] lastFetch;
   logic [31:0] lastInstr;
   logic [3:0]  expMask;
   logic [31:0] srcData;
   logic [31:0] replData;
   logic [31:0] expData;
   logic [31:0] gotData;

   `include "tbProgram.svh"

   quarkCore quarkCore_inst (
      .clk(clk), .resetn(resetn), .memAddr(memAddr), .memWdata(memWdata),
      .memMask(memMask), .memRstrb(memRstrb), .memWstrb(memWstrb),
      .memRdata(memRdata), .memRbusy(memRbusy), .memWbusy(memWbusy)
   );

   always #10 clk = ~clk;

   // LCG step, two upper-middle bits give 0 to 3 busy cycles
   function automatic logic [1:0] nextBusyCount();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState[17:16];
   endfunction

   function automatic int wordIndex(logic [31:0] addr);
      return int'(addr[11:2]);
   endfunction

   // Branches and jumps break the straight-line fetch order
   function automatic bit isJump(logic [31:0] instr);
      return (instr[6:0] == 7'h63) || (instr[6:0] == 7'h67) || (instr[6:0] == 7'h6f);
   endfunction

   // Byte lanes for a store size and offset
   function automatic logic [3:0] laneMask(logic [2:0] f3, logic [1:0] offset);
      case (f3[1:0])
         2'b00:   return 4'b0001 << offset;
         2'b01:   return offset[1] ? 4'b1100 : 4'b0011;
         default: return 4'b1111;
      endcase
   endfunction

   task automatic reportFailure(string what);
      failureCount++;
      $display("Error at %0t: %s", $time, what);
   endtask

   task automatic reportMismatch(string name, logic [31:0] got, logic [31:0] expected);
      mismatchCount++;
      $display("Mismatch %s: got %h, expected %h", name, got, expected);
   endtask

   // Memory model, busy raised from the cycle after a strobe
   always @(posedge clk) begin
      if (!resetn) begin
         memRbusy <= 1'b0;
         memWbusy <= 1'b0;
         busyLeft <= 0;
      end else if (memRstrb || memWstrb) begin
         stretch = nextBusyCount();
         busyLeft <= stretch;
         memRbusy <= memRstrb && (stretch != 0);
         memWbusy <= memWstrb && (stretch != 0);
         // Read data held until the next strobe
         if (memRstrb) begin
            memRdata <= mem[wordIndex(memAddr)];
         end
         for (int b = 0; b < 4; b++) begin
            if (memWstrb && memMask[b]) begin
               mem[wordIndex(memAddr)][8*b +: 8] <= memWdata[8*b +: 8];
            end
         end
      end else if (busyLeft != 0) begin
         busyLeft <= busyLeft - 1;
         if (busyLeft == 1) begin
            memRbusy <= 1'b0;
            memWbusy <= 1'b0;
         end
      end
   end

   // Strobe, fetch order and store lane checks
   always @(posedge clk) begin
      if (!resetn) begin
         // First edge still sees the unreset core
         if (resetEdges > 0) begin
            assert (!memRstrb && !memWstrb)
               else reportFailure("memory strobe high during reset");
         end
         resetEdges++;
      end else begin
         if (cyclesOut == 0) begin
            assert (!memRstrb && !memWstrb)
               else reportFailure("memory strobe high in the first cycle after reset");
         end
         cyclesOut++;
         assert (!(memRstrb && memWstrb))
            else reportFailure("read and write strobes high in the same cycle");
         // Instruction fetches stay below the data area
         if (memRstrb && (memAddr[11:0] < 12'h200)) begin
            if (!fetchSeen) begin
               assert (memAddr == baseAddr) else reportMismatch("memAddr", memAddr, baseAddr);
            end else if (!isJump(lastInstr)) begin
               assert (memAddr == lastFetch + 32'd4)
                  else reportMismatch("memAddr", memAddr, lastFetch + 32'd4);
            end
            fetchSeen = 1'b1;
            lastFetch = memAddr;
            lastInstr = mem[wordIndex(memAddr)];
         end
         if (memWstrb) begin
            expMask = laneMask(lastInstr[14:12], memAddr[1:0]);
            // Register value of this store, low byte or halfword repeated across the word
            srcData = storeData[wordIndex(lastFetch)];
            replData = (lastInstr[13:12] == 2'b00) ? {4{srcData[7:0]}} :
                       (lastInstr[13:12] == 2'b01) ? {2{srcData[15:0]}} : srcData;
            // Only the enabled lanes carry data
            expData = '0;
            gotData = '0;
            for (int b = 0; b < 4; b++) begin
               if (expMask[b]) begin
                  expData[8*b +: 8] = replData[8*b +: 8];
                  gotData[8*b +: 8] = memWdata[8*b +: 8];
               end
            end
            assert (memMask == expMask) else reportMismatch("memMask", memMask, expMask);
            assert (gotData == expData) else reportMismatch("memWdata", gotData, expData);
            if ((memAddr == slotAddr(doneSlot)) && (memWdata == doneWord)) begin
               doneSeen <= 1'b1;
            end
         end
      end
   end

   initial begin
      logic [31:0] addr;
      clk = 1'b0;
      resetn = 1'b0;
      memRdata = '0;
      memRbusy = 1'b0;
      memWbusy = 1'b0;
      lcgState = 32'hc5d0_4db0;
      // Fill word depends on the full word index
      for (int i = 0; i < 1024; i++) begin
         mem[i] = (i * 32'h9e37_79b9) ^ 32'h5bd1_e995;
      end
      buildProgram();
      foreach (progImage[i]) begin
         mem[i] = progImage[i];
      end
      mem[wordIndex(baseAddr + 32'h200)] = dataWord;
      repeat (16) @(posedge clk);
      resetn <= 1'b1;
      for (int n = 0; (n < 20000) && !doneSeen; n++) begin
         @(posedge clk);
      end
      if (!doneSeen) begin
         reportFailure("timeout waiting for the completion store");
      end else begin
         foreach (expSlot[i]) begin
            addr = slotAddr(expSlot[i]);
            assert (mem[wordIndex(addr)] == expValue[i])
               else reportMismatch($sformatf("mem[%h]", addr), mem[wordIndex(addr)], expValue[i]);
         end
         foreach (skipSlot[i]) begin
            addr = slotAddr(skipSlot[i]);
            assert (mem[wordIndex(addr)] != markerWord)
               else reportFailure($sformatf("taken branch did not skip the store to %h", addr));
         end
      end
      $display("Errors: %0d mismatches, %0d other failures", mismatchCount, failureCount);
      if ((mismatchCount + failureCount) == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// File: src.f
+incdir+dv
design/rvCorePkg.sv
design/instrDecoder.sv
design/regFile.sv
design/aluUnit.sv
design/loadStoreUnit.sv
design/coreSequencer.sv
design/quarkCore.sv
dv/quarkCoreTb.sv
